/* Bender.yml */
package:
  name: rob

sources:
  - files:
      - design/rob_pkg.sv
      - design/rob_queue.sv
      - design/rob_retire.sv
      - design/rob_flush_mask.sv
      - design/rob_top.sv
  - target: test
    files:
      - tests/tb_clock_gen.sv
      - tests/rob_chk.sv
      - tests/tb_rob.sv

/* build.f */
design/rob_pkg.sv
design/rob_queue.sv
design/rob_retire.sv
design/rob_flush_mask.sv
design/rob_top.sv
tests/tb_clock_gen.sv
tests/rob_chk.sv
tests/tb_rob.sv

/* design/rob_flush_mask.sv */
// ROB recovery masks
// Captures the architectural and physical registers written by entries
// younger than the head at the moment of a flush

`timescale 1ns/100ps
`default_nettype none

module rob_flush_mask import rob_pkg::*; (
  input  wire logic                         clock,
  input  wire logic                         reset,
  input  wire rob_index_t                   head_index,
  input  wire rob_count_t                   occupancy,
  input  wire arch_reg_t  [rob_size-1:0]    entry_arch_dest,
  input  wire phys_reg_t  [rob_size-1:0]    entry_phys_dest,
  input  wire logic                         flush,
  output arf_mask_t                         arf_recover,
  output prf_mask_t                         prf_recover
);

  arf_mask_t arf_next;
  prf_mask_t prf_next;

  ////////////////////////////////////////////////////////////
  // mask over the younger entries
  ////////////////////////////////////////////////////////////

  always_comb begin
    rob_index_t idx;
    arf_next = '0;
    prf_next = '0;
    // offset 0 is the faulting head itself and is left out
    for (int i = 1; i < rob_size; i++) begin
      idx = head_index + rob_index_t'(i);
      if (rob_count_t'(i) < occupancy && entry_arch_dest[idx] != '0) begin
        arf_next[entry_arch_dest[idx]] = 1'b1;
        prf_next[entry_phys_dest[idx]] = 1'b1;  // goes back to the free list
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      arf_recover <= '0;
      prf_recover <= '0;
    end else if (flush) begin
      arf_recover <= arf_next;  // held until the next flush
      prf_recover <= prf_next;
    end
  end

endmodule

`default_nettype wire

/* design/rob_pkg.sv */
// ROB package
// Sizes, widths and the retire state type shared by the re-order buffer blocks

`default_nettype none

package rob_pkg;

  ////////////////////////////////////////////////////////////
  // sizes
  ////////////////////////////////////////////////////////////

  localparam int rob_size       = 16;
  localparam int rob_index_size = 4;
  localparam int rename_width   = 2;  // micro-ops per rename bundle
  localparam int commit_width   = 2;  // completion ports and retires per cycle
  localparam int arf_int_size   = 32;
  localparam int prf_int_size   = 64;

  ////////////////////////////////////////////////////////////
  // field types
  ////////////////////////////////////////////////////////////

  typedef logic [31:0] pc_t;
  typedef logic [4:0]  arch_reg_t;  // zero means no destination
  typedef logic [5:0]  phys_reg_t;

  typedef logic [rob_index_size-1:0] rob_index_t;
  typedef logic [rob_index_size:0]   rob_count_t;  // one bit wider to hold a full queue

  typedef logic [arf_int_size-1:0] arf_mask_t;
  typedef logic [prf_int_size-1:0] prf_mask_t;

  ////////////////////////////////////////////////////////////
  // retire state machine
  ////////////////////////////////////////////////////////////

  typedef enum logic {
    retire_run,
    retire_flush
  } retire_state_t;

endpackage

`default_nettype wire

/* design/rob_queue.sv */
// ROB entry queue
// Circular storage of in-flight micro-ops with head pointer and occupancy.
// Allocates rename bundles at the tail, marks completions, pops retired entries.

`timescale 1ns/100ps
`default_nettype none

module rob_queue import rob_pkg::*; (
  input  wire logic                                 clock,
  input  wire logic                                 reset,
  input  wire logic                                 input_valid,
  input  wire logic       [rename_width-1:0]        in_valid,
  input  wire pc_t        [rename_width-1:0]        in_pc,
  input  wire arch_reg_t  [rename_width-1:0]        in_arch_dest,
  input  wire phys_reg_t  [rename_width-1:0]        in_phys_dest,
  input  wire phys_reg_t  [rename_width-1:0]        in_phys_old,
  input  wire logic       [commit_width-1:0]        complete_valid,
  input  wire rob_index_t [commit_width-1:0]        complete_rob_index,
  input  wire logic       [commit_width-1:0]        complete_exception,
  input  wire logic       [$clog2(commit_width+1)-1:0] retire_count,
  input  wire logic                                 flush,
  output logic                                      allocatable,
  output logic            [rename_width-1:0]        out_valid,
  output pc_t             [rename_width-1:0]        out_pc,
  output rob_index_t      [rename_width-1:0]        out_rob_index,
  output logic            [commit_width-1:0]        win_valid,
  output logic            [commit_width-1:0]        win_done,
  output logic            [commit_width-1:0]        win_exception,
  output pc_t             [commit_width-1:0]        win_pc,
  output arch_reg_t       [commit_width-1:0]        win_arch_dest,
  output phys_reg_t       [commit_width-1:0]        win_phys_dest,
  output phys_reg_t       [commit_width-1:0]        win_phys_old,
  output rob_index_t                                head_index,
  output rob_count_t                                occupancy,
  output arch_reg_t       [rob_size-1:0]            entry_arch_dest,
  output phys_reg_t       [rob_size-1:0]            entry_phys_dest
);

  rob_index_t              head;
  rob_count_t              count;
  logic                    alloc_ok;   // enough room for a full bundle next cycle
  logic     [rob_size-1:0] done_q;
  logic     [rob_size-1:0] exc_q;
  pc_t                     pc_q  [rob_size];
  phys_reg_t               old_q [rob_size];

  logic                    accept;
  rob_index_t              tail;
  rob_index_t              lane_index [rename_width];
  rob_count_t              push_count;
  rob_count_t              count_next;

  assign accept      = input_valid & allocatable;
  assign tail        = head + rob_index_t'(count);
  assign allocatable = alloc_ok & ~flush;  // no allocation while the queue is being flushed
  assign head_index  = head;
  assign occupancy   = count;

  ////////////////////////////////////////////////////////////
  // allocation slots and next occupancy
  ////////////////////////////////////////////////////////////

  always_comb begin
    rob_index_t slot;
    slot       = tail;
    push_count = '0;
    for (int i = 0; i < rename_width; i++) begin
      lane_index[i] = slot;  // valid lanes pack onto consecutive entries
      if (in_valid[i]) begin
        slot       = slot + rob_index_t'(1);
        push_count = push_count + rob_count_t'(1);
      end
    end
    if (!accept) begin
      push_count = '0;
    end
  end

  always_comb begin
    if (flush) begin
      count_next = '0;
    end else begin
      count_next = count - rob_count_t'(retire_count) + push_count;
    end
  end

  ////////////////////////////////////////////////////////////
  // control state
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      head      <= '0;
      count     <= '0;
      alloc_ok  <= 1'b0;
      done_q    <= '0;
      exc_q     <= '0;
      out_valid <= '0;
    end else begin
      count    <= count_next;
      alloc_ok <= (count_next <= rob_count_t'(rob_size - rename_width));
      if (flush) begin
        head <= head + rob_index_t'(1);  // the faulting entry is consumed by the flush
      end else begin
        head <= head + rob_index_t'(retire_count);
      end
      for (int i = 0; i < rename_width; i++) begin
        out_valid[i] <= accept & in_valid[i];
        if (accept && in_valid[i]) begin
          done_q[lane_index[i]] <= 1'b0;
          exc_q[lane_index[i]]  <= 1'b0;
        end
      end
      for (int p = 0; p < commit_width; p++) begin
        if (complete_valid[p]) begin
          done_q[complete_rob_index[p]] <= 1'b1;
          exc_q[complete_rob_index[p]]  <= complete_exception[p];
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // entry payload and tagged bundle
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    for (int i = 0; i < rename_width; i++) begin
      if (accept && in_valid[i]) begin
        pc_q[lane_index[i]]            <= in_pc[i];
        entry_arch_dest[lane_index[i]] <= in_arch_dest[i];
        entry_phys_dest[lane_index[i]] <= in_phys_dest[i];
        old_q[lane_index[i]]           <= in_phys_old[i];
      end
      out_pc[i]        <= in_pc[i];
      out_rob_index[i] <= lane_index[i];
    end
  end

  // the two oldest entries as seen by retirement
  always_comb begin
    rob_index_t idx;
    for (int i = 0; i < commit_width; i++) begin
      idx              = head + rob_index_t'(i);
      win_valid[i]     = count > rob_count_t'(i);
      win_done[i]      = done_q[idx];
      win_exception[i] = exc_q[idx];
      win_pc[i]        = pc_q[idx];
      win_arch_dest[i] = entry_arch_dest[idx];
      win_phys_dest[i] = entry_phys_dest[idx];
      win_phys_old[i]  = old_q[idx];
    end
  end

endmodule

`default_nettype wire

/* design/rob_retire.sv */
// ROB retire logic
// Commits done entries in order from the head and flushes on a head exception

`timescale 1ns/100ps
`default_nettype none

module rob_retire import rob_pkg::*; (
  input  wire logic                                 clock,
  input  wire logic                                 reset,
  input  wire logic       [commit_width-1:0]        win_valid,
  input  wire logic       [commit_width-1:0]        win_done,
  input  wire logic       [commit_width-1:0]        win_exception,
  input  wire pc_t        [commit_width-1:0]        win_pc,
  input  wire arch_reg_t  [commit_width-1:0]        win_arch_dest,
  input  wire phys_reg_t  [commit_width-1:0]        win_phys_dest,
  input  wire phys_reg_t  [commit_width-1:0]        win_phys_old,
  input  wire rob_index_t                           head_index,
  output logic            [$clog2(commit_width+1)-1:0] retire_count,
  output logic                                      flush,
  output logic            [commit_width-1:0]        commit_valid,
  output pc_t             [commit_width-1:0]        commit_pc,
  output arch_reg_t       [commit_width-1:0]        commit_arch_dest,
  output phys_reg_t       [commit_width-1:0]        commit_phys_dest,
  output phys_reg_t       [commit_width-1:0]        commit_phys_old,
  output logic                                      recover,
  output pc_t                                       recover_pc,
  output rob_index_t                                recover_rob_index
);

  retire_state_t           state;
  logic [commit_width-1:0] retire_mask;

  ////////////////////////////////////////////////////////////
  // commit selection
  ////////////////////////////////////////////////////////////

  always_comb begin
    logic open;
    open         = (state == retire_run);
    retire_count = '0;
    for (int i = 0; i < commit_width; i++) begin
      open           = open & win_valid[i] & win_done[i] & ~win_exception[i];
      retire_mask[i] = open;  // stays contiguous from the head
      if (open) begin
        retire_count = retire_count + 1'b1;
      end
    end
    flush = (state == retire_run) & win_valid[0] & win_done[0] & win_exception[0];
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state        <= retire_run;
      commit_valid <= '0;
      recover      <= 1'b0;
    end else begin
      commit_valid <= retire_mask;
      recover      <= flush;
      case (state)
        retire_run:   if (flush) state <= retire_flush;
        retire_flush: state <= retire_run;  // recovery reported, resume commits
        default:      state <= retire_run;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // commit and recovery payload
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    commit_pc        <= win_pc;
    commit_arch_dest <= win_arch_dest;
    commit_phys_dest <= win_phys_dest;
    commit_phys_old  <= win_phys_old;
    if (flush) begin
      recover_pc        <= win_pc[0];
      recover_rob_index <= head_index;
    end
  end

endmodule

`default_nettype wire

/* design/rob_top.sv */
// Re-order buffer top level
// Ties the entry queue, retire logic and recovery mask builder together

`timescale 1ns/100ps
`default_nettype none

module rob_top import rob_pkg::*; (
  input  wire logic                          clock,
  input  wire logic                          reset,
  input  wire logic                          input_valid,
  input  wire logic       [rename_width-1:0] in_valid,
  input  wire pc_t        [rename_width-1:0] in_pc,
  input  wire arch_reg_t  [rename_width-1:0] in_arch_dest,
  input  wire phys_reg_t  [rename_width-1:0] in_phys_dest,
  input  wire phys_reg_t  [rename_width-1:0] in_phys_old,
  input  wire logic       [commit_width-1:0] complete_valid,
  input  wire rob_index_t [commit_width-1:0] complete_rob_index,
  input  wire logic       [commit_width-1:0] complete_exception,
  output logic                               allocatable,
  output logic            [rename_width-1:0] out_valid,
  output pc_t             [rename_width-1:0] out_pc,
  output rob_index_t      [rename_width-1:0] out_rob_index,
  output logic            [commit_width-1:0] commit_valid,
  output pc_t             [commit_width-1:0] commit_pc,
  output arch_reg_t       [commit_width-1:0] commit_arch_dest,
  output phys_reg_t       [commit_width-1:0] commit_phys_dest,
  output phys_reg_t       [commit_width-1:0] commit_phys_old,
  output logic                               recover,
  output pc_t                                recover_pc,
  output rob_index_t                         recover_rob_index,
  output arf_mask_t                          arf_recover,
  output prf_mask_t                          prf_recover
);

  logic       [$clog2(commit_width+1)-1:0] retire_count;
  logic                                    flush;
  logic       [commit_width-1:0]           win_valid;
  logic       [commit_width-1:0]           win_done;
  logic       [commit_width-1:0]           win_exception;
  pc_t        [commit_width-1:0]           win_pc;
  arch_reg_t  [commit_width-1:0]           win_arch_dest;
  phys_reg_t  [commit_width-1:0]           win_phys_dest;
  phys_reg_t  [commit_width-1:0]           win_phys_old;
  rob_index_t                              head_index;
  rob_count_t                              occupancy;
  arch_reg_t  [rob_size-1:0]               entry_arch_dest;
  phys_reg_t  [rob_size-1:0]               entry_phys_dest;

  rob_queue rob_queue_i (
    .clock, .reset,
    .input_valid, .in_valid, .in_pc, .in_arch_dest, .in_phys_dest, .in_phys_old,
    .complete_valid, .complete_rob_index, .complete_exception,
    .retire_count, .flush,
    .allocatable, .out_valid, .out_pc, .out_rob_index,
    .win_valid, .win_done, .win_exception, .win_pc,
    .win_arch_dest, .win_phys_dest, .win_phys_old,
    .head_index, .occupancy, .entry_arch_dest, .entry_phys_dest
  );

  rob_retire rob_retire_i (
    .clock, .reset,
    .win_valid, .win_done, .win_exception, .win_pc,
    .win_arch_dest, .win_phys_dest, .win_phys_old,
    .head_index, .retire_count, .flush,
    .commit_valid, .commit_pc, .commit_arch_dest, .commit_phys_dest, .commit_phys_old,
    .recover, .recover_pc, .recover_rob_index
  );

  rob_flush_mask rob_flush_mask_i (
    .clock, .reset,
    .head_index, .occupancy, .entry_arch_dest, .entry_phys_dest,
    .flush, .arf_recover, .prf_recover
  );

endmodule

`default_nettype wire

/* tests/rob_chk.sv */
// ROB protocol checks
// Concurrent assertions bound onto the re-order buffer top level

`timescale 1ns/100ps
`default_nettype none

module rob_chk import rob_pkg::*; (
  input wire logic                    clock,
  input wire logic                    reset,
  input wire logic                    recover,
  input wire logic                    allocatable,
  input wire rob_count_t              occupancy,
  input wire logic [commit_width-1:0] commit_valid
);

  recover_one_cycle: assert property (
    @(posedge clock) disable iff (reset) recover |=> !recover
  ) else $error("recover held for more than one cycle");

  full_blocks_alloc: assert property (
    @(posedge clock) disable iff (reset) (occupancy > 14) |-> !allocatable
  ) else $error("allocatable high with fewer than two free entries");

  // lane 1 never commits without lane 0
  commit_contiguous: assert property (
    @(posedge clock) disable iff (reset) !(commit_valid[1] && !commit_valid[0])
  ) else $error("commit lanes not contiguous from lane 0");

endmodule

bind rob_top rob_chk rob_chk_i (
  .clock, .reset, .recover, .allocatable, .occupancy, .commit_valid
);

`default_nettype wire

/* tests/rob_golden.txt */
# B v0 v1 tag0 tag1 | pc arch phys old (lane 0) | pc arch phys old (lane 1), all hex
# C valid index exception (port 0) valid index exception (port 1); I cycles; F hold cycles
# E pc arch phys old (expected commit); R pc index arf_mask prf_mask (expected recovery)
# D name waits for every expected result and reports the test
B 1 0 0 0 100 01 21 01 0 0 0 0
B 1 1 1 2 104 02 22 02 108 03 23 03
B 0 1 0 3 0 0 0 0 10c 04 24 04
C 1 0 0 1 1 0
E 100 01 21 01
E 104 02 22 02
C 1 2 0 1 3 0
E 108 03 23 03
E 10c 04 24 04
D tagging
B 1 1 4 5 200 05 25 05 204 06 26 06
B 1 1 6 7 208 07 27 07 20c 00 28 08
C 1 7 0 1 5 0
I 3
C 1 6 0 1 4 0
E 200 05 25 05
E 204 06 26 06
E 208 07 27 07
E 20c 00 28 08
D order
B 1 1 8 9 300 01 30 01 304 02 31 02
B 1 1 a b 308 03 32 03 30c 04 33 04
B 1 1 c d 310 00 34 00 314 05 35 05
B 1 1 e f 318 04 36 33 31c 1f 37 1f
B 1 1 0 1 320 06 38 06 324 00 39 00
B 1 1 2 3 328 07 3a 07 32c 08 3b 08
B 1 1 4 5 330 09 3c 09 334 0a 3d 0a
B 1 1 6 7 338 0b 3e 0b 33c 0c 3f 0c
F 4
C 1 8 0 1 9 0
E 300 01 30 01
E 304 02 31 02
B 1 1 8 9 340 0d 10 0d 344 0e 11 0e
D full
C 1 a 1 0 0 0
R 308 a 80007ff0 fde8000000030000
D flush
B 1 1 b c 400 01 12 01 404 02 13 02
C 1 b 0 1 c 0
E 400 01 12 01
E 404 02 13 02
D restart

/* tests/tb_clock_gen.sv */
// Testbench clock and reset
// 100 ns clock with a synchronous reset held for the first 16 cycles

`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
  output logic clock,
  output logic reset
);

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  initial begin
    reset = 1'b1;
    repeat (16) @(posedge clock);
    #1 reset = 1'b0;  // released with the other inputs, just after the edge
  end

endmodule

`default_nettype wire

/* tests/tb_rob.sv */
// ROB testbench
// Replays the golden record file against rob_top and checks tags, commits and recovery

`timescale 1ns/100ps
`default_nettype none

module tb_rob import rob_pkg::*; ();

  localparam string golden_path = "tests/rob_golden.txt";

  logic clock, reset, input_valid, allocatable, recover;
  logic [1:0] in_valid, complete_valid, complete_exception, out_valid, commit_valid;
  pc_t [1:0] in_pc, out_pc, commit_pc;
  arch_reg_t [1:0] in_arch_dest, commit_arch_dest;
  phys_reg_t [1:0] in_phys_dest, in_phys_old, commit_phys_dest, commit_phys_old;
  rob_index_t [1:0] complete_rob_index, out_rob_index;
  pc_t recover_pc;
  rob_index_t recover_rob_index;
  arf_mask_t arf_recover;
  prf_mask_t prf_recover;

  logic [35:0]  exp_tag[$];      // pc, rob index
  logic [48:0]  exp_commit[$];   // pc, arch dest, phys dest, old phys
  logic [131:0] exp_recover[$];  // pc, index, arf mask, prf mask
  logic [15:0]  lfsr;
  int fd, record_count, errors, checks, test_errors;

  tb_clock_gen clock_gen_i (.clock, .reset);

  rob_top rob_top_i (.*);

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic next_cycle();
    @(posedge clock);
    #1;
    input_valid    = 1'b0;
    complete_valid = '0;
  endtask

  task automatic idle_gap();
    int gap;
    lfsr = lfsr_next(lfsr);
    gap  = lfsr[0];
    lfsr = lfsr_next(lfsr);
    gap  = gap + 2 * lfsr[0];
    repeat (gap) next_cycle();
  endtask

  ////////////////////////////////////////////////////////////
  // monitor
  ////////////////////////////////////////////////////////////

  always @(negedge clock) begin
    if (!reset) begin
      for (int l = 0; l < 2; l++) begin
        if (out_valid[l]) begin
          checks++;
          if (exp_tag.size() == 0) begin
            errors++;
            $display("unexpected bundle output on lane %0d at %0t ns", l, $time);
          end else if ({out_pc[l], out_rob_index[l]} !== exp_tag.pop_front()) begin
            errors++;
            $display("** Error [%0t ns] lane %0d tagged %h with pc %h", $time, l,
                     out_rob_index[l], out_pc[l]);
          end
        end
      end
      for (int l = 0; l < 2; l++) begin
        if (commit_valid[l]) begin
          checks++;
          if (exp_commit.size() == 0) begin
            errors++;
            $display("unexpected commit of pc %h at %0t ns", commit_pc[l], $time);
          end else if ({commit_pc[l], commit_arch_dest[l], commit_phys_dest[l],
                        commit_phys_old[l]} !== exp_commit[0]) begin
            errors++;
            $display("** Error [%0t ns] commit pc %h, expected pc %h", $time,
                     commit_pc[l], exp_commit[0][48:17]);
            void'(exp_commit.pop_front());
          end else begin
            void'(exp_commit.pop_front());
          end
        end
      end
      if (recover) begin
        checks++;
        if (exp_recover.size() == 0) begin
          errors++;
          $display("unexpected recovery at %0t ns", $time);
        end else if ({recover_pc, recover_rob_index, arf_recover, prf_recover}
                     !== exp_recover.pop_front()) begin
          errors++;
          $display("** Error [%0t ns] recovery pc %h index %h arf %h prf %h", $time,
                   recover_pc, recover_rob_index, arf_recover, prf_recover);
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // record replay
  ////////////////////////////////////////////////////////////

  task automatic count_records();
    string line;
    record_count = 0;
    while ($fgets(line, fd) > 0) begin
      if (line.len() > 1 && line.getc(0) != "#") record_count++;
    end
    $fclose(fd);
    fd = $fopen(golden_path, "r");
  endtask

  task automatic run_records();
    string kind, line, name;
    logic [31:0] f[12];
    logic [63:0] prf_mask;
    int n, cycles;
    while (!$feof(fd)) begin
      kind = "";
      n = $fscanf(fd, " %s", kind);
      if (n != 1 || kind.len() == 0) begin
        kind = "";
      end else if (kind.getc(0) == "#") begin
        n = $fgets(line, fd);  // column description
      end else if (kind == "B") begin
        n = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h", f[0], f[1], f[2], f[3],
                    f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11]);
        if (f[0][0]) exp_tag.push_back({f[4], f[2][3:0]});
        if (f[1][0]) exp_tag.push_back({f[8], f[3][3:0]});
        idle_gap();
        next_cycle();
        in_valid = {f[1][0], f[0][0]};
        in_pc = {f[8], f[4]};
        in_arch_dest = {f[9][4:0], f[5][4:0]};
        in_phys_dest = {f[10][5:0], f[6][5:0]};
        in_phys_old = {f[11][5:0], f[7][5:0]};
        input_valid = 1'b1;
        @(negedge clock);
        while (!allocatable) @(negedge clock);  // taken at the coming edge
      end else if (kind == "C") begin
        n = $fscanf(fd, "%h %h %h %h %h %h", f[0], f[1], f[2], f[3], f[4], f[5]);
        idle_gap();
        next_cycle();
        complete_valid = {f[3][0], f[0][0]};
        complete_rob_index = {f[4][3:0], f[1][3:0]};
        complete_exception = {f[5][0], f[2][0]};
      end else if (kind == "I") begin
        n = $fscanf(fd, "%d", cycles);
        repeat (cycles) next_cycle();
      end else if (kind == "F") begin
        n = $fscanf(fd, "%d", cycles);
        next_cycle();
        input_valid = 1'b1;  // hold the last bundle against a full queue
        repeat (cycles) begin
          @(negedge clock);
          checks++;
          if (allocatable) begin
            errors++;
            $display("** Error [%0t ns] allocatable high on a full queue", $time);
          end
        end
      end else if (kind == "E") begin
        n = $fscanf(fd, "%h %h %h %h", f[0], f[1], f[2], f[3]);
        exp_commit.push_back({f[0], f[1][4:0], f[2][5:0], f[3][5:0]});
      end else if (kind == "R") begin
        n = $fscanf(fd, "%h %h %h %h", f[0], f[1], f[2], prf_mask);
        exp_recover.push_back({f[0], f[1][3:0], f[2], prf_mask});
      end else if (kind == "D") begin
        n = $fscanf(fd, " %s", name);
        next_cycle();
        while (exp_tag.size() + exp_commit.size() + exp_recover.size() > 0) begin
          @(negedge clock);
        end
        $display("test %s finished with %0d errors", name, errors - test_errors);
        test_errors = errors;
      end else begin
        errors++;
        $display("unknown record kind %s in the golden file", kind);
      end
    end
  endtask

  initial begin
    input_valid = 1'b0;
    in_valid = '0;
    in_pc = '0;
    in_arch_dest = '0;
    in_phys_dest = '0;
    in_phys_old = '0;
    complete_valid = '0;
    complete_rob_index = '0;
    complete_exception = '0;
    lfsr = 16'd55;
    errors = 0;
    checks = 0;
    test_errors = 0;
    fd = $fopen(golden_path, "r");
    if (fd == 0) begin
      $display("could not open the golden file %s", golden_path);
      $display("TEST FAILED");
      $finish;
    end else begin
      count_records();
      fork
        begin
          #(record_count * 40 * 100);
          $display("timeout after %0d cycles, the run did not finish", record_count * 40);
          $display("TEST FAILED");
          $finish;
        end
      join_none
      @(negedge reset);
      run_records();
      repeat (4) next_cycle();
      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
        $display("TEST PASSED");
      end else begin
        $display("TEST FAILED");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire
